// ==== common/mips_ex_defines.svh ====
`ifndef MIPS_EX_DEFINES_SVH
`define MIPS_EX_DEFINES_SVH

// --------------------------------------------------
// execute stage widths
// --------------------------------------------------

// data path and address width
`define MIPS_DATA_W 32

// register index and shift amount width
`define MIPS_REG_W 5

// alu operation code width
`define MIPS_OP_W 6

// forwarding select width
`define MIPS_FWD_W 3

`endif

// ==== common/mips_ex_pkg.sv ====
`include "mips_ex_defines.svh"

package mips_ex_pkg;

    // --------------------------------------------------
    // encodings
    // --------------------------------------------------

    // codes follow the r-type funct field where one exists
    typedef enum logic [`MIPS_OP_W-1:0] {
        ALU_SLL  = 6'b000000,
        ALU_SRL  = 6'b000010,
        ALU_SRA  = 6'b000011,
        ALU_LUI  = 6'b001111,
        ALU_ADD  = 6'b100000,
        ALU_SUB  = 6'b100010,
        ALU_AND  = 6'b100100,
        ALU_OR   = 6'b100101,
        ALU_XOR  = 6'b100110,
        ALU_NOR  = 6'b100111,
        ALU_SLT  = 6'b101010,
        ALU_SLTU = 6'b101011
    } alu_op_e;

    typedef enum logic [`MIPS_FWD_W-1:0] {
        FWD_REG   = 3'b000,
        FWD_EXMEM = 3'b001,
        FWD_MEMWB = 3'b010
    } fwd_sel_e;

    // --------------------------------------------------
    // pipeline bundles
    // --------------------------------------------------

    typedef struct packed {
        logic                    valid;
        logic [`MIPS_DATA_W-1:0] pc4;
        logic [`MIPS_DATA_W-1:0] imm_ext;
        logic [`MIPS_DATA_W-1:0] rd_data1;
        logic [`MIPS_DATA_W-1:0] rd_data2;
        logic [`MIPS_REG_W-1:0]  rs;
        logic [`MIPS_REG_W-1:0]  rt;
        logic [`MIPS_REG_W-1:0]  rd;
        logic [`MIPS_REG_W-1:0]  shamt;
        alu_op_e                 alu_op;
        logic                    alu_src;
        logic                    shamt_sel;
        logic                    reg_dst;
        logic                    reg_write;
    } idex_t;

    // store_data carries the forwarded operand a
    typedef struct packed {
        logic                    valid;
        logic [`MIPS_DATA_W-1:0] alu_result;
        logic [`MIPS_DATA_W-1:0] branch_target;
        logic [`MIPS_DATA_W-1:0] store_data;
        logic                    alu_zero;
        logic [`MIPS_REG_W-1:0]  dest;
        logic                    reg_write;
    } exmem_t;

    typedef struct packed {
        logic                    reg_write;
        logic [`MIPS_REG_W-1:0]  dest;
        logic [`MIPS_DATA_W-1:0] wdata;
    } memwb_t;

endpackage

// ==== ex/alu.sv ====
`timescale 1ns/1ps

`include "mips_ex_defines.svh"

module alu
    import mips_ex_pkg::*;
    (
        input  logic [`MIPS_DATA_W-1:0] i_data_a,
        input  logic [`MIPS_DATA_W-1:0] i_data_b,
        input  logic [`MIPS_REG_W-1:0]  i_shamt,
        input  logic                    i_shamt_sel,
        input  alu_op_e                 i_op,
        output logic [`MIPS_DATA_W-1:0] o_result,
        output logic                    o_zero
    );

    localparam int HALF_W = `MIPS_DATA_W / 2;

    logic [`MIPS_REG_W-1:0] shift_amt;
    logic                   lt_signed;
    logic                   lt_unsigned;

    // --------------------------------------------------
    // shift amount
    // --------------------------------------------------

    // shamt field for sll/srl/sra, rs low bits for the variable forms
    assign shift_amt = i_shamt_sel ? i_shamt : i_data_a[`MIPS_REG_W-1:0];

    assign lt_signed   = $signed(i_data_a) < $signed(i_data_b);
    assign lt_unsigned = i_data_a < i_data_b;

    // --------------------------------------------------
    // operation select
    // --------------------------------------------------

    always_comb begin
        case (i_op)
            ALU_ADD: o_result = i_data_a + i_data_b;
            ALU_SUB: o_result = i_data_a - i_data_b;
            ALU_AND: o_result = i_data_a & i_data_b;
            ALU_OR:  o_result = i_data_a | i_data_b;
            ALU_XOR: o_result = i_data_a ^ i_data_b;
            ALU_NOR: o_result = ~(i_data_a | i_data_b);
            ALU_SLT: begin
                o_result = {{(`MIPS_DATA_W-1){1'b0}}, lt_signed};
            end
            ALU_SLTU: begin
                o_result = {{(`MIPS_DATA_W-1){1'b0}}, lt_unsigned};
            end
            ALU_SLL: o_result = i_data_b << shift_amt;
            ALU_SRL: o_result = i_data_b >> shift_amt;
            ALU_SRA: o_result = $unsigned($signed(i_data_b) >>> shift_amt);
            ALU_LUI: begin
                o_result = {i_data_b[HALF_W-1:0], {HALF_W{1'b0}}};
            end
            default: o_result = '0;
        endcase
    end

    assign o_zero = (o_result == '0);

endmodule

// ==== ex/ex_stage.sv ====
`timescale 1ns/1ps

`include "mips_ex_defines.svh"

module ex_stage
    import mips_ex_pkg::*;
    (
        input  idex_t    i_idex,
        input  fwd_sel_e i_fwd_a,
        input  fwd_sel_e i_fwd_b,
        input  exmem_t   i_exmem,
        input  memwb_t   i_memwb,
        output exmem_t   o_exmem
    );

    logic [`MIPS_DATA_W-1:0] reg_a;
    logic [`MIPS_DATA_W-1:0] reg_b;
    logic [`MIPS_DATA_W-1:0] data_b;
    logic [`MIPS_DATA_W-1:0] alu_result;
    logic                    alu_zero;

    // pick register file, ex/mem result or mem/wb write data
    function automatic logic [`MIPS_DATA_W-1:0] fwd_mux(
        input fwd_sel_e                sel,
        input logic [`MIPS_DATA_W-1:0] reg_val,
        input logic [`MIPS_DATA_W-1:0] exmem_val,
        input logic [`MIPS_DATA_W-1:0] memwb_val
    );
        case (sel)
            FWD_EXMEM: return exmem_val;
            FWD_MEMWB: return memwb_val;
            default:   return reg_val;
        endcase
    endfunction

    // --------------------------------------------------
    // operand muxes
    // --------------------------------------------------

    assign reg_a  = fwd_mux(i_fwd_a, i_idex.rd_data1, i_exmem.alu_result, i_memwb.wdata);
    assign reg_b  = fwd_mux(i_fwd_b, i_idex.rd_data2, i_exmem.alu_result, i_memwb.wdata);
    assign data_b = i_idex.alu_src ? i_idex.imm_ext : reg_b;

    alu alu (
        .i_data_a    (reg_a),
        .i_data_b    (data_b),
        .i_shamt     (i_idex.shamt),
        .i_shamt_sel (i_idex.shamt_sel),
        .i_op        (i_idex.alu_op),
        .o_result    (alu_result),
        .o_zero      (alu_zero)
    );

    // --------------------------------------------------
    // outgoing bundle
    // --------------------------------------------------

    always_comb begin
        o_exmem.valid         = i_idex.valid;
        o_exmem.alu_result    = alu_result;
        o_exmem.alu_zero      = alu_zero;
        // word offset to byte offset
        o_exmem.branch_target = i_idex.pc4 + (i_idex.imm_ext << 2);
        o_exmem.store_data    = reg_a;
        o_exmem.dest          = i_idex.reg_dst ? i_idex.rd : i_idex.rt;
        o_exmem.reg_write     = i_idex.reg_write;
    end

endmodule

// ==== ex/forward_unit.sv ====
`timescale 1ns/1ps

`include "mips_ex_defines.svh"

module forward_unit
    import mips_ex_pkg::*;
    (
        input  logic [`MIPS_REG_W-1:0] i_rs,
        input  logic [`MIPS_REG_W-1:0] i_rt,
        input  exmem_t                 i_exmem,
        input  memwb_t                 i_memwb,
        output fwd_sel_e               o_fwd_a,
        output fwd_sel_e               o_fwd_b
    );

    logic exmem_live;
    logic memwb_live;

    // --------------------------------------------------
    // producer qualification
    // --------------------------------------------------

    // register zero is hardwired so it never forwards
    assign exmem_live = i_exmem.valid && i_exmem.reg_write && (i_exmem.dest != '0);
    assign memwb_live = i_memwb.reg_write && (i_memwb.dest != '0);

    // --------------------------------------------------
    // select per source, ex/mem is the younger result
    // --------------------------------------------------

    always_comb begin
        if (exmem_live && (i_exmem.dest == i_rs)) begin
            o_fwd_a = FWD_EXMEM;
        end else if (memwb_live && (i_memwb.dest == i_rs)) begin
            o_fwd_a = FWD_MEMWB;
        end else begin
            o_fwd_a = FWD_REG;
        end
    end

    always_comb begin
        if (exmem_live && (i_exmem.dest == i_rt)) begin
            o_fwd_b = FWD_EXMEM;
        end else if (memwb_live && (i_memwb.dest == i_rt)) begin
            o_fwd_b = FWD_MEMWB;
        end else begin
            o_fwd_b = FWD_REG;
        end
    end

endmodule

// ==== mips_ex.f ====
+incdir+common
common/mips_ex_pkg.sv
rtl/pipe_reg.sv
ex/alu.sv
ex/forward_unit.sv
ex/ex_stage.sv
rtl/ex_pipeline_top.sv
sim/ex_checker.sv
sim/tb_ex_pipeline.sv

// ==== rtl/ex_pipeline_top.sv ====
`timescale 1ns/1ps

module ex_pipeline_top
    import mips_ex_pkg::*;
    (
        input  logic   i_clk,
        input  logic   i_rst_n,
        input  idex_t  i_idex,
        input  memwb_t i_memwb,
        output exmem_t o_exmem
    );

    idex_t    idex_q;
    exmem_t   exmem_d;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;

    // --------------------------------------------------
    // id/ex register
    // --------------------------------------------------

    pipe_reg #(
        .payload_t (idex_t)
    ) idex_reg (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_d     (i_idex),
        .o_q     (idex_q)
    );

    // --------------------------------------------------
    // execute
    // --------------------------------------------------

    // o_exmem doubles as the ex/mem forwarding source
    forward_unit forward_unit (
        .i_rs    (idex_q.rs),
        .i_rt    (idex_q.rt),
        .i_exmem (o_exmem),
        .i_memwb (i_memwb),
        .o_fwd_a (fwd_a),
        .o_fwd_b (fwd_b)
    );

    ex_stage ex_stage (
        .i_idex  (idex_q),
        .i_fwd_a (fwd_a),
        .i_fwd_b (fwd_b),
        .i_exmem (o_exmem),
        .i_memwb (i_memwb),
        .o_exmem (exmem_d)
    );

    // --------------------------------------------------
    // ex/mem register
    // --------------------------------------------------

    pipe_reg #(
        .payload_t (exmem_t)
    ) exmem_reg (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_d     (exmem_d),
        .o_q     (o_exmem)
    );

endmodule

// ==== rtl/pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg
    #(
        parameter type payload_t = logic
    )
    (
        input  logic     i_clk,
        input  logic     i_rst_n,
        input  payload_t i_d,
        output payload_t o_q
    );

    // whole bundle clears so valid and reg_write drop on reset
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_q <= '0;
        end else begin
            o_q <= i_d;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds and runs the execute stage testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_ex_pipeline
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -j 0 \
    --top-module "$TOP" \
    --Mdir "$BUILD_DIR" \
    -f mips_ex.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/V$TOP" | tee "$LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
    echo "simulation exited with an error"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
    echo "failure reported, see $LOG"
    exit 1
fi

echo "run complete, log in $LOG"
exit 0

// ==== sim/ex_checker.sv ====
`timescale 1ns/1ps

`include "mips_ex_defines.svh"

module ex_checker
    import mips_ex_pkg::*;
    (
        input  logic                   i_clk,
        input  logic                   i_rst_n,
        input  idex_t                  i_idex,
        input  logic [`MIPS_REG_W-1:0] i_exp_dest,
        input  exmem_t                 i_exmem,
        output int                     o_checks,
        output int                     o_errors
    );

    logic [`MIPS_DATA_W-1:0] shadow [2**`MIPS_REG_W];
    bit                      known [2**`MIPS_REG_W];
    exmem_t                  exp_q [$];
    int                      checks = 0;
    int                      errors = 0;

    assign o_checks = checks;
    assign o_errors = errors;

    // program-order value, or the register file read if never written
    function automatic logic [`MIPS_DATA_W-1:0] operand(
        input logic [`MIPS_REG_W-1:0]  idx,
        input logic [`MIPS_DATA_W-1:0] fetched
    );
        return known[idx] ? shadow[idx] : fetched;
    endfunction

    function automatic exmem_t predict(input idex_t bundle, input logic [`MIPS_REG_W-1:0] dest);
        exmem_t                  pred;
        logic [`MIPS_DATA_W-1:0] a;
        logic [`MIPS_DATA_W-1:0] b;
        logic [`MIPS_DATA_W-1:0] res;
        logic [`MIPS_REG_W-1:0]  amt;
        pred = '0;
        a = operand(bundle.rs, bundle.rd_data1);
        b = bundle.alu_src ? bundle.imm_ext : operand(bundle.rt, bundle.rd_data2);
        amt = bundle.shamt_sel ? bundle.shamt : a[`MIPS_REG_W-1:0];
        case (bundle.alu_op)
            ALU_ADD:  res = a + b;
            ALU_SUB:  res = a - b;
            ALU_AND:  res = a & b;
            ALU_OR:   res = a | b;
            ALU_XOR:  res = a ^ b;
            ALU_NOR:  res = ~(a | b);
            ALU_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: res = (a < b) ? 32'd1 : 32'd0;
            ALU_SLL:  res = b << amt;
            ALU_SRL:  res = b >> amt;
            ALU_SRA:  res = 32'($signed(b) >>> amt);
            ALU_LUI:  res = {b[15:0], 16'h0000};
            default:  res = '0;
        endcase
        pred.valid         = bundle.valid;
        pred.reg_write     = bundle.reg_write;
        pred.alu_result    = res;
        pred.alu_zero      = (res == '0);
        pred.branch_target = bundle.pc4 + {bundle.imm_ext[29:0], 2'b00};
        pred.store_data    = a;
        pred.dest          = dest;
        return pred;
    endfunction

    task automatic check_field(input string name, input logic [31:0] want, input logic [31:0] got);
        if (got !== want) begin
            errors++;
            $display("MISMATCH t=%0t %s expected=%h got=%h", $time, name, want, got);
        end
    endtask

    task automatic compare_bundle(input exmem_t want);
        checks++;
        check_field("o_exmem.valid", 32'(want.valid), 32'(i_exmem.valid));
        check_field("o_exmem.reg_write", 32'(want.reg_write), 32'(i_exmem.reg_write));
        if (want.valid) begin
            check_field("o_exmem.alu_result", want.alu_result, i_exmem.alu_result);
            check_field("o_exmem.alu_zero", 32'(want.alu_zero), 32'(i_exmem.alu_zero));
            check_field("o_exmem.branch_target", want.branch_target, i_exmem.branch_target);
            check_field("o_exmem.store_data", want.store_data, i_exmem.store_data);
            check_field("o_exmem.dest", 32'(want.dest), 32'(i_exmem.dest));
        end
    endtask

    // --------------------------------------------------
    // sample between edges, two bundles in flight
    // --------------------------------------------------

    always @(negedge i_clk) begin : sample
        exmem_t pred;
        exmem_t idle;
        idle = '0;
        if (!i_rst_n) begin
            exp_q.delete();
            exp_q.push_back(idle);
            exp_q.push_back(idle);
        end else begin
            if (exp_q.size() == 2) begin
                compare_bundle(exp_q.pop_front());
            end
            pred = predict(i_idex, i_exp_dest);
            if (pred.valid && pred.reg_write && (pred.dest != '0)) begin
                shadow[pred.dest] = pred.alu_result;
                known[pred.dest]  = 1'b1;
            end
            exp_q.push_back(pred);
        end
    end

endmodule

// ==== sim/tb_ex_pipeline.sv ====
`timescale 1ns/1ps

`include "mips_ex_defines.svh"

module tb_ex_pipeline
    import mips_ex_pkg::*;
    ();

    localparam int          CLK_PERIOD = 10;
    localparam int          RST_CYCLES = 8;
    localparam logic [31:0] SEED       = 32'h94e4_8126;
    localparam logic [31:0] PC_BASE    = 32'h0040_0000;

    // flags are {alu_src, shamt_sel, reg_dst, reg_write}
    typedef struct packed {
        logic                    valid;
        alu_op_e                 op;
        logic [`MIPS_REG_W-1:0]  rs;
        logic [`MIPS_REG_W-1:0]  rt;
        logic [`MIPS_REG_W-1:0]  rd;
        logic [`MIPS_REG_W-1:0]  shamt;
        logic [`MIPS_DATA_W-1:0] imm;
        logic [3:0]              flags;
        logic [`MIPS_REG_W-1:0]  exp_dest;
    } stim_row_t;

    logic                    clk;
    logic                    rst_n;
    idex_t                   idex;
    memwb_t                  memwb;
    memwb_t                  memwb_next;
    exmem_t                  exmem;
    logic [`MIPS_REG_W-1:0]  exp_dest;
    logic [`MIPS_DATA_W-1:0] regfile [2**`MIPS_REG_W];
    stim_row_t               rows [$];
    bit                      table_ready = 1'b0;
    int                      checks;
    int                      mismatches;
    int                      other_errors = 0;

    ex_pipeline_top i_ex_pipeline_top (
        .i_clk   (clk),
        .i_rst_n (rst_n),
        .i_idex  (idex),
        .i_memwb (memwb),
        .o_exmem (exmem)
    );

    ex_checker exmem_check (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_idex     (idex),
        .i_exp_dest (exp_dest),
        .i_exmem    (exmem),
        .o_checks   (checks),
        .o_errors   (mismatches)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // mem/wb stage model one cycle behind o_exmem
    always @(negedge clk) begin
        if (!rst_n) begin
            memwb_next = '0;
        end else begin
            memwb_next.reg_write = exmem.valid && exmem.reg_write;
            memwb_next.dest      = exmem.dest;
            memwb_next.wdata     = exmem.alu_result;
        end
    end

    task automatic add_row(
        input logic                    v,
        input alu_op_e                 op,
        input logic [`MIPS_REG_W-1:0]  rs, rt, rd, shamt,
        input logic [`MIPS_DATA_W-1:0] imm,
        input logic [3:0]              flags,
        input logic [`MIPS_REG_W-1:0]  dest
    );
        stim_row_t row;
        row = '{v, op, rs, rt, rd, shamt, imm, flags, dest};
        rows.push_back(row);
    endtask

    task automatic build_table();
        add_row(1'b0, ALU_ADD,  5'd0,  5'd0,  5'd0,  5'd0, 32'h0000_0000, 4'b0000, 5'd0);
        // independent operations
        add_row(1'b1, ALU_ADD,  5'd1,  5'd2,  5'd3,  5'd0, 32'h0000_0004, 4'b0011, 5'd3);
        add_row(1'b1, ALU_SUB,  5'd4,  5'd5,  5'd6,  5'd0, 32'h0000_0008, 4'b0011, 5'd6);
        add_row(1'b1, ALU_AND,  5'd7,  5'd8,  5'd9,  5'd0, 32'hffff_fffc, 4'b0011, 5'd9);
        add_row(1'b1, ALU_OR,   5'd10, 5'd11, 5'd12, 5'd0, 32'h0000_0010, 4'b0011, 5'd12);
        add_row(1'b1, ALU_XOR,  5'd13, 5'd14, 5'd15, 5'd0, 32'h0000_0000, 4'b0011, 5'd15);
        add_row(1'b1, ALU_NOR,  5'd16, 5'd17, 5'd18, 5'd0, 32'h0000_0020, 4'b0011, 5'd18);
        // r23 becomes negative for the compares and the arithmetic shifts
        add_row(1'b1, ALU_LUI,  5'd0,  5'd23, 5'd0,  5'd0, 32'h0000_8000, 4'b1001, 5'd23);
        add_row(1'b1, ALU_SLL,  5'd0,  5'd1,  5'd26, 5'd4, 32'h0000_0000, 4'b0111, 5'd26);
        add_row(1'b1, ALU_SRL,  5'd0,  5'd2,  5'd27, 5'd7, 32'h0000_0000, 4'b0111, 5'd27);
        add_row(1'b1, ALU_SLT,  5'd23, 5'd24, 5'd0,  5'd0, 32'h0000_0001, 4'b1001, 5'd24);
        add_row(1'b1, ALU_SLTU, 5'd23, 5'd25, 5'd0,  5'd0, 32'h0000_0001, 4'b1001, 5'd25);
        add_row(1'b1, ALU_SRA,  5'd0,  5'd23, 5'd28, 5'd9, 32'h0000_0000, 4'b0111, 5'd28);
        add_row(1'b1, ALU_SLL,  5'd4,  5'd5,  5'd29, 5'd0, 32'h0000_0000, 4'b0011, 5'd29);
        add_row(1'b1, ALU_SRA,  5'd7,  5'd23, 5'd30, 5'd0, 32'h0000_0000, 4'b0011, 5'd30);
        add_row(1'b1, ALU_SUB,  5'd1,  5'd1,  5'd31, 5'd0, 32'h0000_0000, 4'b0011, 5'd31);
        // ex/mem then mem/wb forwarding
        add_row(1'b1, ALU_ADD,  5'd1,  5'd2,  5'd10, 5'd0, 32'h0000_0000, 4'b0011, 5'd10);
        add_row(1'b1, ALU_ADD,  5'd10, 5'd3,  5'd11, 5'd0, 32'h0000_0000, 4'b0011, 5'd11);
        add_row(1'b1, ALU_ADD,  5'd10, 5'd10, 5'd12, 5'd0, 32'h0000_0000, 4'b0011, 5'd12);
        // both stages hold r13 and the younger one wins
        add_row(1'b1, ALU_ADD,  5'd1,  5'd2,  5'd13, 5'd0, 32'h0000_0000, 4'b0011, 5'd13);
        add_row(1'b1, ALU_OR,   5'd13, 5'd5,  5'd13, 5'd0, 32'h0000_0000, 4'b0011, 5'd13);
        add_row(1'b1, ALU_SUB,  5'd13, 5'd13, 5'd14, 5'd0, 32'h0000_0000, 4'b0011, 5'd14);
        // r0 destination and a cleared reg_write in both stages
        add_row(1'b1, ALU_ADD,  5'd1,  5'd2,  5'd0,  5'd0, 32'h0000_0000, 4'b0011, 5'd0);
        add_row(1'b1, ALU_ADD,  5'd0,  5'd0,  5'd15, 5'd0, 32'h0000_0000, 4'b0011, 5'd15);
        add_row(1'b1, ALU_ADD,  5'd0,  5'd3,  5'd16, 5'd0, 32'h0000_0000, 4'b0010, 5'd16);
        add_row(1'b1, ALU_ADD,  5'd16, 5'd16, 5'd17, 5'd0, 32'h0000_0000, 4'b0011, 5'd17);
        add_row(1'b1, ALU_ADD,  5'd16, 5'd17, 5'd21, 5'd0, 32'h0000_0000, 4'b0011, 5'd21);
        // immediate operand, branch target, rt destination, back-to-back chain
        add_row(1'b1, ALU_ADD,  5'd1,  5'd18, 5'd0,  5'd0, 32'h0000_0100, 4'b1001, 5'd18);
        add_row(1'b1, ALU_ADD,  5'd18, 5'd19, 5'd0,  5'd0, 32'hffff_fffc, 4'b1001, 5'd19);
        add_row(1'b1, ALU_XOR,  5'd19, 5'd18, 5'd20, 5'd0, 32'h0000_0000, 4'b0011, 5'd20);
        add_row(1'b1, ALU_ADD,  5'd20, 5'd19, 5'd20, 5'd0, 32'h0000_0000, 4'b0011, 5'd20);
        add_row(1'b0, ALU_ADD,  5'd0,  5'd0,  5'd0,  5'd0, 32'h0000_0000, 4'b0000, 5'd0);
        add_row(1'b0, ALU_ADD,  5'd0,  5'd0,  5'd0,  5'd0, 32'h0000_0000, 4'b0000, 5'd0);
    endtask

    // write-back lands before the decode read of the same cycle
    task automatic apply_row(input stim_row_t row, input int idx);
        @(posedge clk);
        #1;
        memwb = memwb_next;
        if (memwb.reg_write && (memwb.dest != '0)) begin
            regfile[memwb.dest] = memwb.wdata;
        end
        idex.valid    = row.valid;
        idex.pc4      = PC_BASE + 32'(4 * (idx + 1));
        idex.imm_ext  = row.imm;
        idex.rd_data1 = regfile[row.rs];
        idex.rd_data2 = regfile[row.rt];
        idex.rs       = row.rs;
        idex.rt       = row.rt;
        idex.rd       = row.rd;
        idex.shamt    = row.shamt;
        idex.alu_op   = row.op;
        {idex.alu_src, idex.shamt_sel, idex.reg_dst, idex.reg_write} = row.flags;
        exp_dest      = row.exp_dest;
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n      = 1'b0;
        idex       = '0;
        // a live bundle held during reset must not reach o_exmem
        idex.valid     = 1'b1;
        idex.reg_write = 1'b1;
        memwb      = '0;
        memwb_next = '0;
        exp_dest   = '0;
        regfile[0] = '0;
        for (int i = 1; i < 2**`MIPS_REG_W; i++) begin
            regfile[i] = $urandom();
        end
        build_table();
        table_ready = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        idex  = '0;
        foreach (rows[n]) begin
            apply_row(rows[n], n);
        end
        repeat (3) @(negedge clk);
        #1;
        if (checks == 0) begin
            $display("no EX/MEM bundle was compared");
            other_errors++;
        end
        $display("checks=%0d mismatches=%0d other_errors=%0d", checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        #(CLK_PERIOD * (rows.size() + 20));
        $display("watchdog expired before the stimulus table finished");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule
